// File: Makefile
SIM  := obj_dir/Vtb_exec_tile
SRCS := $(wildcard design/*.sv design/*.svh tb/*.sv)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) exec_tile.f
	verilator --binary --timing -f exec_tile.f --top-module tb_exec_tile -Mdir obj_dir

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

// File: design/alu_exec.sv
// Integer ALU
`include "exec_tile_defs.svh"
`default_nettype none

module alu_exec (
  issue_if.exec                    alu_issue,
  output logic [`RNID_W-1:0]       o_rs1_rnid,
  output logic [`RNID_W-1:0]       o_rs2_rnid,
  input  logic [`XLEN-1:0]         i_rs1_data,
  input  logic [`XLEN-1:0]         i_rs2_data,
  output exec_tile_pkg::phy_wr_t   o_phy_wr,
  output exec_tile_pkg::done_rpt_t o_done
);

  import exec_tile_pkg::*;

  localparam int SHAMT_W = $clog2(`XLEN);

  logic [`XLEN-1:0] w_op_a;
  logic [`XLEN-1:0] w_op_b;
  logic [`XLEN-1:0] w_result;

  assign o_rs1_rnid = alu_issue.rs1_rnid;
  assign o_rs2_rnid = alu_issue.rs2_rnid;

  // Second operand is imm or rs2
  assign w_op_a = i_rs1_data;
  assign w_op_b = alu_issue.use_imm ? alu_issue.imm : i_rs2_data;

  always_comb begin
    case (alu_op_t'(alu_issue.op))
      ADD:     w_result = w_op_a + w_op_b;
      SUB:     w_result = w_op_a - w_op_b;
      AND:     w_result = w_op_a & w_op_b;
      OR:      w_result = w_op_a | w_op_b;
      XOR:     w_result = w_op_a ^ w_op_b;
      SLL:     w_result = w_op_a << w_op_b[SHAMT_W-1:0];
      SRL:     w_result = w_op_a >> w_op_b[SHAMT_W-1:0];
      SLT:     w_result = {{(`XLEN-1){1'b0}}, $signed(w_op_a) < $signed(w_op_b)};
      default: w_result = '0;
    endcase
  end

  // Result toward writeback
  assign o_phy_wr.valid  = alu_issue.valid;
  assign o_phy_wr.rnid   = alu_issue.rd_rnid;
  assign o_phy_wr.data   = w_result;

  assign o_done.valid    = alu_issue.valid;
  assign o_done.cmt_id   = alu_issue.cmt_id;

endmodule

`default_nettype wire

// File: design/bru_exec.sv
// Branch resolution unit
`include "exec_tile_defs.svh"
`default_nettype none

module bru_exec (
  issue_if.exec                    bru_issue,
  output logic [`RNID_W-1:0]       o_rs1_rnid,
  output logic [`RNID_W-1:0]       o_rs2_rnid,
  input  logic [`XLEN-1:0]         i_rs1_data,
  input  logic [`XLEN-1:0]         i_rs2_data,
  output exec_tile_pkg::phy_wr_t   o_phy_wr,
  output exec_tile_pkg::done_rpt_t o_done,
  output exec_tile_pkg::br_upd_t   o_br_upd
);

  import exec_tile_pkg::*;

  logic             w_is_jal;
  logic             w_taken;
  logic [`XLEN-1:0] w_target;

  assign o_rs1_rnid = bru_issue.rs1_rnid;
  assign o_rs2_rnid = bru_issue.rs2_rnid;

  assign w_is_jal = (br_op_t'(bru_issue.op) == JAL);

  // Branch condition
  always_comb begin
    case (br_op_t'(bru_issue.op))
      BEQ:     w_taken = (i_rs1_data == i_rs2_data);
      BNE:     w_taken = (i_rs1_data != i_rs2_data);
      BLT:     w_taken = ($signed(i_rs1_data) <  $signed(i_rs2_data));
      BGE:     w_taken = ($signed(i_rs1_data) >= $signed(i_rs2_data));
      JAL:     w_taken = 1'b1;
      default: w_taken = 1'b0;
    endcase
  end

  assign w_target = bru_issue.pc + bru_issue.imm;

  // Link write for JAL only
  assign o_phy_wr.valid  = bru_issue.valid & w_is_jal;
  assign o_phy_wr.rnid   = bru_issue.rd_rnid;
  assign o_phy_wr.data   = bru_issue.pc + `XLEN'd4;

  assign o_done.valid    = bru_issue.valid;
  assign o_done.cmt_id   = bru_issue.cmt_id;

  assign o_br_upd.valid  = bru_issue.valid;
  assign o_br_upd.taken  = w_taken;
  assign o_br_upd.target = w_target;
  assign o_br_upd.cmt_id = bru_issue.cmt_id;

endmodule

`default_nettype wire

// File: design/disp_decode.sv
// Dispatch group decode
`include "exec_tile_defs.svh"
`default_nettype none

module disp_decode (
  input  logic                      i_clk,
  input  logic                      i_arst_n,
  input  logic                      i_disp_valid,
  input  exec_tile_pkg::disp_inst_t i_disp_inst [`DISP_SIZE],
  issue_if.decode                   alu_issue [`ALU_INST_NUM],
  issue_if.decode                   bru_issue
);

  import exec_tile_pkg::*;

  localparam int SEL_W = (`DISP_SIZE > 1) ? $clog2(`DISP_SIZE) : 1;

  logic [`DISP_SIZE-1:0] w_slot_ok;
  logic                  w_bru_vld;
  logic [SEL_W-1:0]      w_bru_idx;

  // Group valid, slot valid and not illegal
  always_comb begin
    for (int d = 0; d < `DISP_SIZE; d++) begin
      w_slot_ok[d] = i_disp_valid & i_disp_inst[d].valid & ~i_disp_inst[d].illegal;
    end
  end

  // Lowest branch slot wins
  always_comb begin
    w_bru_vld = 1'b0;
    w_bru_idx = '0;
    for (int d = `DISP_SIZE - 1; d >= 0; d--) begin
      if (w_slot_ok[d] && (i_disp_inst[d].cat == CAT_BR)) begin
        w_bru_vld = 1'b1;
        w_bru_idx = SEL_W'(d);
      end
    end
  end

  // --------------------
  // ALU issue from slot d to ALU d
  generate
    for (genvar a = 0; a < `ALU_INST_NUM; a++) begin : g_alu_issue
      always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
          alu_issue[a].valid <= 1'b0;
        end else begin
          alu_issue[a].valid <= w_slot_ok[a] & (i_disp_inst[a].cat == CAT_ALU);
        end
      end

      always_ff @(posedge i_clk) begin
        alu_issue[a].op       <= i_disp_inst[a].op;
        alu_issue[a].use_imm  <= i_disp_inst[a].use_imm;
        alu_issue[a].cmt_id   <= i_disp_inst[a].cmt_id;
        alu_issue[a].rd_rnid  <= i_disp_inst[a].rd_rnid;
        alu_issue[a].rs1_rnid <= i_disp_inst[a].rs1_rnid;
        alu_issue[a].rs2_rnid <= i_disp_inst[a].rs2_rnid;
        alu_issue[a].imm      <= i_disp_inst[a].imm;
        alu_issue[a].pc       <= i_disp_inst[a].pc;
      end
    end
  endgenerate

  // --------------------
  // Branch unit issue
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      bru_issue.valid <= 1'b0;
    end else begin
      bru_issue.valid <= w_bru_vld;
    end
  end

  always_ff @(posedge i_clk) begin
    bru_issue.op       <= i_disp_inst[w_bru_idx].op;
    bru_issue.use_imm  <= i_disp_inst[w_bru_idx].use_imm;
    bru_issue.cmt_id   <= i_disp_inst[w_bru_idx].cmt_id;
    bru_issue.rd_rnid  <= i_disp_inst[w_bru_idx].rd_rnid;
    bru_issue.rs1_rnid <= i_disp_inst[w_bru_idx].rs1_rnid;
    bru_issue.rs2_rnid <= i_disp_inst[w_bru_idx].rs2_rnid;
    bru_issue.imm      <= i_disp_inst[w_bru_idx].imm;
    bru_issue.pc       <= i_disp_inst[w_bru_idx].pc;
  end

endmodule

`default_nettype wire

// File: design/exec_tile.sv
// Execution tile top
`include "exec_tile_defs.svh"
`default_nettype none

module exec_tile (
  input  logic                      i_clk,
  input  logic                      i_arst_n,
  input  logic                      i_disp_valid,
  input  exec_tile_pkg::disp_inst_t i_disp_inst     [`DISP_SIZE],
  output logic                      o_wb_valid      [`WB_PORT_NUM],
  output logic [`RNID_W-1:0]        o_wb_rnid       [`WB_PORT_NUM],
  output logic [`XLEN-1:0]          o_wb_data       [`WB_PORT_NUM],
  output logic                      o_done_valid    [`WB_PORT_NUM],
  output logic [`CMT_ID_W-1:0]      o_done_cmt_id   [`WB_PORT_NUM],
  output logic                      o_br_upd_valid,
  output logic                      o_br_upd_taken,
  output logic [`XLEN-1:0]          o_br_upd_target,
  output logic [`CMT_ID_W-1:0]      o_br_upd_cmt_id
);

  import exec_tile_pkg::*;

  localparam int BRU_RD_BASE = `ALU_INST_NUM * 2;

  issue_if alu_issue_if [`ALU_INST_NUM] ();
  issue_if bru_issue_if ();

  logic [`RNID_W-1:0] w_rd_rnid [`RD_PORT_NUM];
  logic [`XLEN-1:0]   w_rd_data [`RD_PORT_NUM];

  phy_wr_t   w_unit_wr   [`WB_PORT_NUM];
  done_rpt_t w_unit_done [`WB_PORT_NUM];
  br_upd_t   w_unit_br_upd;
  phy_wr_t   w_wb        [`WB_PORT_NUM];
  done_rpt_t w_done      [`WB_PORT_NUM];
  br_upd_t   w_br_upd;

  disp_decode u_disp_decode (
    .i_clk        (i_clk),
    .i_arst_n     (i_arst_n),
    .i_disp_valid (i_disp_valid),
    .i_disp_inst  (i_disp_inst),
    .alu_issue    (alu_issue_if),
    .bru_issue    (bru_issue_if)
  );

  // --------------------
  // ALUs on their port bases
  generate
    for (genvar a = 0; a < `ALU_INST_NUM; a++) begin : g_alu
      alu_exec u_alu_exec (
        .alu_issue  (alu_issue_if[a]),
        .o_rs1_rnid (w_rd_rnid[a * 2 + 0]),
        .o_rs2_rnid (w_rd_rnid[a * 2 + 1]),
        .i_rs1_data (w_rd_data[a * 2 + 0]),
        .i_rs2_data (w_rd_data[a * 2 + 1]),
        .o_phy_wr   (w_unit_wr[`ALU_WB_BASE + a]),
        .o_done     (w_unit_done[`ALU_WB_BASE + a])
      );
    end
  endgenerate

  bru_exec u_bru_exec (
    .bru_issue  (bru_issue_if),
    .o_rs1_rnid (w_rd_rnid[BRU_RD_BASE + 0]),
    .o_rs2_rnid (w_rd_rnid[BRU_RD_BASE + 1]),
    .i_rs1_data (w_rd_data[BRU_RD_BASE + 0]),
    .i_rs2_data (w_rd_data[BRU_RD_BASE + 1]),
    .o_phy_wr   (w_unit_wr[`BRU_WB_BASE]),
    .o_done     (w_unit_done[`BRU_WB_BASE]),
    .o_br_upd   (w_unit_br_upd)
  );

  phy_regfile u_phy_regfile (
    .i_clk     (i_clk),
    .i_arst_n  (i_arst_n),
    .i_rd_rnid (w_rd_rnid),
    .o_rd_data (w_rd_data),
    .i_wr      (w_wb)
  );

  writeback_stage u_writeback_stage (
    .i_clk       (i_clk),
    .i_arst_n    (i_arst_n),
    .i_unit_wr   (w_unit_wr),
    .i_unit_done (w_unit_done),
    .i_br_upd    (w_unit_br_upd),
    .o_wb        (w_wb),
    .o_done      (w_done),
    .o_br_upd    (w_br_upd)
  );

  // --------------------
  // Flatten to plain ports
  generate
    for (genvar p = 0; p < `WB_PORT_NUM; p++) begin : g_out
      assign o_wb_valid[p]    = w_wb[p].valid;
      assign o_wb_rnid[p]     = w_wb[p].rnid;
      assign o_wb_data[p]     = w_wb[p].data;
      assign o_done_valid[p]  = w_done[p].valid;
      assign o_done_cmt_id[p] = w_done[p].cmt_id;
    end
  endgenerate

  assign o_br_upd_valid  = w_br_upd.valid;
  assign o_br_upd_taken  = w_br_upd.taken;
  assign o_br_upd_target = w_br_upd.target;
  assign o_br_upd_cmt_id = w_br_upd.cmt_id;

endmodule

`default_nettype wire

// File: design/exec_tile_defs.svh
// Execution tile sizes
`ifndef EXEC_TILE_DEFS_SVH
`define EXEC_TILE_DEFS_SVH
`default_nettype none

// Dispatch and unit counts
`define DISP_SIZE     2
`define ALU_INST_NUM  2

// Data path and id widths
`define XLEN          32
`define RNID_W        5
`define CMT_ID_W      6

// --------------------
// Writeback port bases
`define WB_PORT_NUM   3
`define ALU_WB_BASE   0
`define BRU_WB_BASE   (`ALU_INST_NUM)

// Two read ports per ALU, then two for the BRU
`define RD_PORT_NUM   (`ALU_INST_NUM * 2 + 2)

`default_nettype wire
`endif

// File: design/exec_tile_pkg.sv
// Execution tile types
`include "exec_tile_defs.svh"
`default_nettype none

package exec_tile_pkg;

  typedef enum logic [1:0] {
    CAT_ALU   = 2'd0,
    CAT_BR    = 2'd1,
    CAT_OTHER = 2'd2
  } inst_cat_t;

  typedef enum logic [2:0] {
    ADD = 3'd0,
    SUB = 3'd1,
    AND = 3'd2,
    OR  = 3'd3,
    XOR = 3'd4,
    SLL = 3'd5,
    SRL = 3'd6,
    SLT = 3'd7
  } alu_op_t;

  typedef enum logic [2:0] {
    BEQ = 3'd0,
    BNE = 3'd1,
    BLT = 3'd2,
    BGE = 3'd3,
    JAL = 3'd4
  } br_op_t;

  // One slot of a renamed dispatch group
  typedef struct packed {
    logic                 valid;
    logic                 illegal;
    inst_cat_t            cat;
    logic [2:0]           op;
    logic                 use_imm;
    logic [`CMT_ID_W-1:0] cmt_id;
    logic [`RNID_W-1:0]   rd_rnid;
    logic [`RNID_W-1:0]   rs1_rnid;
    logic [`RNID_W-1:0]   rs2_rnid;
    logic [`XLEN-1:0]     imm;
    logic [`XLEN-1:0]     pc;
  } disp_inst_t;

  typedef struct packed {
    logic               valid;
    logic [`RNID_W-1:0] rnid;
    logic [`XLEN-1:0]   data;
  } phy_wr_t;

  typedef struct packed {
    logic                 valid;
    logic [`CMT_ID_W-1:0] cmt_id;
  } done_rpt_t;

  typedef struct packed {
    logic                 valid;
    logic                 taken;
    logic [`XLEN-1:0]     target;
    logic [`CMT_ID_W-1:0] cmt_id;
  } br_upd_t;

endpackage

`default_nettype wire

// File: design/issue_if.sv
// Issue port interface
`include "exec_tile_defs.svh"
`default_nettype none

interface issue_if;

  logic                 valid;
  logic [2:0]           op;
  logic                 use_imm;
  logic [`CMT_ID_W-1:0] cmt_id;
  logic [`RNID_W-1:0]   rd_rnid;
  logic [`RNID_W-1:0]   rs1_rnid;
  logic [`RNID_W-1:0]   rs2_rnid;
  logic [`XLEN-1:0]     imm;
  logic [`XLEN-1:0]     pc;

  // Decode side drives the registered instruction
  modport decode (
    output valid, op, use_imm, cmt_id,
    output rd_rnid, rs1_rnid, rs2_rnid,
    output imm, pc
  );

  // Unit side consumes it
  modport exec (
    input valid, op, use_imm, cmt_id,
    input rd_rnid, rs1_rnid, rs2_rnid,
    input imm, pc
  );

endinterface

`default_nettype wire

// File: design/phy_regfile.sv
// Integer physical register file
`include "exec_tile_defs.svh"
`default_nettype none

module phy_regfile (
  input  logic                   i_clk,
  input  logic                   i_arst_n,
  input  logic [`RNID_W-1:0]     i_rd_rnid [`RD_PORT_NUM],
  output logic [`XLEN-1:0]       o_rd_data [`RD_PORT_NUM],
  input  exec_tile_pkg::phy_wr_t i_wr      [`WB_PORT_NUM]
);

  localparam int REG_NUM = 2 ** `RNID_W;

  logic [`XLEN-1:0] r_regs [REG_NUM];

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      for (int r = 0; r < REG_NUM; r++) begin
        r_regs[r] <= '0;
      end
    end else begin
      for (int w = 0; w < `WB_PORT_NUM; w++) begin
        if (i_wr[w].valid && (i_wr[w].rnid != '0)) begin
          r_regs[i_wr[w].rnid] <= i_wr[w].data;
        end
      end
    end
  end

  // Write-first read with id 0 hardwired to zero
  always_comb begin
    for (int p = 0; p < `RD_PORT_NUM; p++) begin
      o_rd_data[p] = r_regs[i_rd_rnid[p]];
      for (int w = 0; w < `WB_PORT_NUM; w++) begin
        if (i_wr[w].valid && (i_wr[w].rnid == i_rd_rnid[p])) begin
          o_rd_data[p] = i_wr[w].data;
        end
      end
      if (i_rd_rnid[p] == '0) begin
        o_rd_data[p] = '0;
      end
    end
  end

endmodule

`default_nettype wire

// File: design/writeback_stage.sv
// Writeback and done report stage
`include "exec_tile_defs.svh"
`default_nettype none

module writeback_stage (
  input  logic                     i_clk,
  input  logic                     i_arst_n,
  input  exec_tile_pkg::phy_wr_t   i_unit_wr   [`WB_PORT_NUM],
  input  exec_tile_pkg::done_rpt_t i_unit_done [`WB_PORT_NUM],
  input  exec_tile_pkg::br_upd_t   i_br_upd,
  output exec_tile_pkg::phy_wr_t   o_wb        [`WB_PORT_NUM],
  output exec_tile_pkg::done_rpt_t o_done      [`WB_PORT_NUM],
  output exec_tile_pkg::br_upd_t   o_br_upd
);

  logic [`WB_PORT_NUM-1:0] r_wb_vld;
  logic [`WB_PORT_NUM-1:0] r_done_vld;
  logic                    r_br_vld;
  logic [`RNID_W-1:0]      r_wb_rnid   [`WB_PORT_NUM];
  logic [`XLEN-1:0]        r_wb_data   [`WB_PORT_NUM];
  logic [`CMT_ID_W-1:0]    r_done_cmt  [`WB_PORT_NUM];
  logic                    r_br_taken;
  logic [`XLEN-1:0]        r_br_target;
  logic [`CMT_ID_W-1:0]    r_br_cmt;

  // --------------------
  // Valid strobes
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      r_wb_vld   <= '0;
      r_done_vld <= '0;
      r_br_vld   <= 1'b0;
    end else begin
      for (int p = 0; p < `WB_PORT_NUM; p++) begin
        // Writes to x0 are dropped but their done report still goes out
        r_wb_vld[p]   <= i_unit_wr[p].valid & (i_unit_wr[p].rnid != '0);
        r_done_vld[p] <= i_unit_done[p].valid;
      end
      r_br_vld <= i_br_upd.valid;
    end
  end

  // Payload
  always_ff @(posedge i_clk) begin
    for (int p = 0; p < `WB_PORT_NUM; p++) begin
      r_wb_rnid[p]  <= i_unit_wr[p].rnid;
      r_wb_data[p]  <= i_unit_wr[p].data;
      r_done_cmt[p] <= i_unit_done[p].cmt_id;
    end
    r_br_taken  <= i_br_upd.taken;
    r_br_target <= i_br_upd.target;
    r_br_cmt    <= i_br_upd.cmt_id;
  end

  generate
    for (genvar p = 0; p < `WB_PORT_NUM; p++) begin : g_port
      assign o_wb[p].valid    = r_wb_vld[p];
      assign o_wb[p].rnid     = r_wb_rnid[p];
      assign o_wb[p].data     = r_wb_data[p];
      assign o_done[p].valid  = r_done_vld[p];
      assign o_done[p].cmt_id = r_done_cmt[p];
    end
  endgenerate

  assign o_br_upd.valid  = r_br_vld;
  assign o_br_upd.taken  = r_br_taken;
  assign o_br_upd.target = r_br_target;
  assign o_br_upd.cmt_id = r_br_cmt;

endmodule

`default_nettype wire

// File: exec_tile.f
+incdir+design
design/exec_tile_pkg.sv
design/issue_if.sv
design/disp_decode.sv
design/alu_exec.sv
design/bru_exec.sv
design/phy_regfile.sv
design/writeback_stage.sv
design/exec_tile.sv
tb/tb_exec_tile.sv

// File: tb/tb_exec_tile.sv
// Execution tile testbench
`include "exec_tile_defs.svh"
`default_nettype none

module tb_exec_tile;
  timeunit 1ns;
  timeprecision 100ps;

  import exec_tile_pkg::*;

  localparam int RESET_CYCLES  = 10;
  localparam int RANDOM_GROUPS = 600;
  localparam int WAIT_LIMIT    = 50;
  localparam int REG_NUM       = 2 ** `RNID_W;

  // Expected top outputs for one group
  typedef struct packed {
    logic [`WB_PORT_NUM-1:0]                wb_valid;
    logic [`WB_PORT_NUM-1:0][`RNID_W-1:0]   wb_rnid;
    logic [`WB_PORT_NUM-1:0][`XLEN-1:0]     wb_data;
    logic [`WB_PORT_NUM-1:0]                done_valid;
    logic [`WB_PORT_NUM-1:0][`CMT_ID_W-1:0] done_cmt;
    logic                                   br_valid;
    logic                                   br_taken;
    logic [`XLEN-1:0]                       br_target;
    logic [`CMT_ID_W-1:0]                   br_cmt;
  } exp_t;

  logic                 clk;
  logic                 arst_n;
  logic                 disp_valid;
  disp_inst_t           disp_inst     [`DISP_SIZE];
  logic                 wb_valid      [`WB_PORT_NUM];
  logic [`RNID_W-1:0]   wb_rnid       [`WB_PORT_NUM];
  logic [`XLEN-1:0]     wb_data       [`WB_PORT_NUM];
  logic                 done_valid    [`WB_PORT_NUM];
  logic [`CMT_ID_W-1:0] done_cmt_id   [`WB_PORT_NUM];
  logic                 br_upd_valid;
  logic                 br_upd_taken;
  logic [`XLEN-1:0]     br_upd_target;
  logic [`CMT_ID_W-1:0] br_upd_cmt_id;

  int                   seed = 90632;
  exp_t                 exp_q [$];
  logic [`XLEN-1:0]     model_regs [REG_NUM];
  logic [`CMT_ID_W-1:0] next_cmt;
  int                   cnt_alu_wb;
  int                   cnt_x0_done;
  int                   cnt_jal;
  int                   cnt_taken;
  int                   cnt_not_taken;
  int                   cnt_dropped;

  exec_tile dut_i (
    .i_clk           (clk),
    .i_arst_n        (arst_n),
    .i_disp_valid    (disp_valid),
    .i_disp_inst     (disp_inst),
    .o_wb_valid      (wb_valid),
    .o_wb_rnid       (wb_rnid),
    .o_wb_data       (wb_data),
    .o_done_valid    (done_valid),
    .o_done_cmt_id   (done_cmt_id),
    .o_br_upd_valid  (br_upd_valid),
    .o_br_upd_taken  (br_upd_taken),
    .o_br_upd_target (br_upd_target),
    .o_br_upd_cmt_id (br_upd_cmt_id)
  );

  always #2 clk = ~clk;

  // --------------------
  // Helpers
  task automatic report_failure(string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
    if (actual !== expected) begin
      report_failure($sformatf("MISMATCH %s expected 0x%0h actual 0x%0h",
                               name, expected, actual));
    end
  endtask

  task automatic next_edge();
    @(posedge clk);
    #1;
  endtask

  function automatic int rand_below(int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  // Register id 0..7 other than excl
  function automatic int pick_other(int excl);
    int r;
    r = rand_below(7);
    if (r >= excl) begin
      r = r + 1;
    end
    return r;
  endfunction

  function automatic logic [`XLEN-1:0] alu_model(logic [2:0] op, logic [`XLEN-1:0] a,
                                                 logic [`XLEN-1:0] b);
    case (alu_op_t'(op))
      ADD:     return a + b;
      SUB:     return a - b;
      AND:     return a & b;
      OR:      return a | b;
      XOR:     return a ^ b;
      SLL:     return a << b[4:0];
      SRL:     return a >> b[4:0];
      default: return ($signed(a) < $signed(b)) ? `XLEN'd1 : `XLEN'd0;
    endcase
  endfunction

  function automatic logic branch_taken(logic [2:0] op, logic [`XLEN-1:0] a,
                                        logic [`XLEN-1:0] b);
    case (br_op_t'(op))
      BEQ:     return a == b;
      BNE:     return a != b;
      BLT:     return $signed(a) < $signed(b);
      BGE:     return $signed(a) >= $signed(b);
      default: return 1'b1;
    endcase
  endfunction

  task automatic check_outputs(exp_t e, string phase);
    for (int p = 0; p < `WB_PORT_NUM; p++) begin
      check_value($sformatf("%s wb%0d valid", phase, p), 32'(e.wb_valid[p]), 32'(wb_valid[p]));
      if (e.wb_valid[p]) begin
        check_value($sformatf("%s wb%0d rnid", phase, p), 32'(e.wb_rnid[p]), 32'(wb_rnid[p]));
        check_value($sformatf("%s wb%0d data", phase, p), e.wb_data[p], wb_data[p]);
      end
      check_value($sformatf("%s done%0d valid", phase, p), 32'(e.done_valid[p]),
                  32'(done_valid[p]));
      if (e.done_valid[p]) begin
        check_value($sformatf("%s done%0d cmt_id", phase, p), 32'(e.done_cmt[p]),
                    32'(done_cmt_id[p]));
      end
    end
    check_value({phase, " br_upd valid"}, 32'(e.br_valid), 32'(br_upd_valid));
    if (e.br_valid) begin
      check_value({phase, " br_upd taken"}, 32'(e.br_taken), 32'(br_upd_taken));
      check_value({phase, " br_upd target"}, e.br_target, br_upd_target);
      check_value({phase, " br_upd cmt_id"}, 32'(e.br_cmt), 32'(br_upd_cmt_id));
    end
  endtask

  task automatic check_front(string phase);
    exp_t e;
    if (exp_q.size() == 0) begin
      report_failure("expected result queue ran empty");
    end else begin
      e = exp_q.pop_front();
      check_outputs(e, phase);
    end
  endtask

  task automatic wait_reset_release();
    int n;
    n = 0;
    while ((arst_n !== 1'b1) && (n < WAIT_LIMIT)) begin
      @(posedge clk);
      n++;
    end
    if (arst_n !== 1'b1) begin
      report_failure("reset release was not seen within the wait limit");
    end
  endtask

  task automatic drive_idle();
    disp_valid = 1'b0;
    for (int d = 0; d < `DISP_SIZE; d++) begin
      disp_inst[d] = '0;
    end
    exp_q.push_back('0);
  endtask

  // --------------------
  // Random group and its expected results
  task automatic build_group();
    exp_t             e;
    disp_inst_t       s;
    int               rd_pick [`DISP_SIZE];
    int               br_slot;
    int               port;
    logic             ok;
    logic [`XLEN-1:0] a;
    logic [`XLEN-1:0] b;
    e = '0;
    disp_valid = (rand_below(8) != 0);
    br_slot = rand_below(4);
    rd_pick[0] = rand_below(8);
    rd_pick[1] = pick_other(rd_pick[0]);
    for (int d = 0; d < `DISP_SIZE; d++) begin
      s = '0;
      s.valid   = (rand_below(8) != 0);
      s.illegal = (rand_below(12) == 0);
      if (d == br_slot) begin
        s.cat = CAT_BR;
      end else begin
        s.cat = (rand_below(10) == 0) ? CAT_OTHER : CAT_ALU;
      end
      s.op       = (s.cat == CAT_BR) ? 3'(rand_below(5)) : 3'(rand_below(8));
      s.use_imm  = 1'(rand_below(2));
      s.cmt_id   = next_cmt;
      next_cmt   = next_cmt + 1'b1;
      s.rd_rnid  = `RNID_W'(rd_pick[d]);
      s.rs1_rnid = `RNID_W'(pick_other(rd_pick[1 - d]));
      // Equal sources now and then so that BEQ and BGE take
      s.rs2_rnid = (rand_below(4) == 0) ? s.rs1_rnid : `RNID_W'(pick_other(rd_pick[1 - d]));
      s.imm      = $random(seed);
      s.pc       = $random(seed) & 32'hFFFF_FFFC;
      disp_inst[d] = s;

      ok = disp_valid & s.valid & ~s.illegal;
      a  = model_regs[s.rs1_rnid];
      b  = s.use_imm ? s.imm : model_regs[s.rs2_rnid];
      if (!ok || (s.cat == CAT_OTHER)) begin
        cnt_dropped++;
      end else if (s.cat == CAT_ALU) begin
        port = `ALU_WB_BASE + d;
        e.done_valid[port] = 1'b1;
        e.done_cmt[port]   = s.cmt_id;
        if (s.rd_rnid != '0) begin
          e.wb_valid[port] = 1'b1;
          e.wb_rnid[port]  = s.rd_rnid;
          e.wb_data[port]  = alu_model(s.op, a, b);
          cnt_alu_wb++;
        end else begin
          cnt_x0_done++;
        end
      end else begin
        port = `BRU_WB_BASE;
        e.done_valid[port] = 1'b1;
        e.done_cmt[port]   = s.cmt_id;
        e.br_valid  = 1'b1;
        e.br_taken  = branch_taken(s.op, a, model_regs[s.rs2_rnid]);
        e.br_target = s.pc + s.imm;
        e.br_cmt    = s.cmt_id;
        if (br_op_t'(s.op) == JAL) begin
          cnt_jal++;
          if (s.rd_rnid != '0) begin
            e.wb_valid[port] = 1'b1;
            e.wb_rnid[port]  = s.rd_rnid;
            e.wb_data[port]  = s.pc + `XLEN'd4;
          end
        end else if (e.br_taken) begin
          cnt_taken++;
        end else begin
          cnt_not_taken++;
        end
      end
    end
    // Later groups see this group's writes
    for (int p = 0; p < `WB_PORT_NUM; p++) begin
      if (e.wb_valid[p]) begin
        model_regs[e.wb_rnid[p]] = e.wb_data[p];
      end
    end
    exp_q.push_back(e);
  endtask

  initial begin
    #10000;
    report_failure("watchdog expired before the test finished");
  end

  // --------------------
  // Main sequence
  initial begin
    clk        = 1'b0;
    arst_n     = 1'b0;
    disp_valid = 1'b0;
    next_cmt   = '0;
    for (int d = 0; d < `DISP_SIZE; d++) begin
      disp_inst[d] = '0;
    end
    for (int r = 0; r < REG_NUM; r++) begin
      model_regs[r] = '0;
    end
    cnt_alu_wb    = 0;
    cnt_x0_done   = 0;
    cnt_jal       = 0;
    cnt_taken     = 0;
    cnt_not_taken = 0;
    cnt_dropped   = 0;

    for (int i = 0; i < RESET_CYCLES; i++) begin
      next_edge();
      check_outputs('0, "reset");
    end
    arst_n = 1'b1;
    wait_reset_release();

    // Two idle groups already in flight
    exp_q.push_back('0);
    exp_q.push_back('0);
    for (int i = 0; i < RANDOM_GROUPS; i++) begin
      next_edge();
      check_front("random");
      build_group();
    end
    for (int i = 0; i < 3; i++) begin
      next_edge();
      check_front("drain");
      drive_idle();
    end

    $display("alu_wb %0d x0 %0d jal %0d taken %0d not_taken %0d dropped %0d",
             cnt_alu_wb, cnt_x0_done, cnt_jal, cnt_taken, cnt_not_taken, cnt_dropped);
    if ((cnt_alu_wb == 0) || (cnt_x0_done == 0) || (cnt_jal == 0) || (cnt_taken == 0) ||
        (cnt_not_taken == 0) || (cnt_dropped == 0)) begin
      report_failure("random stimulus did not reach every checked case");
    end else begin
      $display("Simulation completed successfully");
      $finish;
    end
  end

endmodule

`default_nettype wire
